// File: files.f
source/dcache_pkg.sv
source/d0_cache_ctrl.sv
source/dcache_bank.sv
source/dcache_way.sv
source/d1_way_select.sv
source/dcache_l1_top.sv
testbench/tb_dcache_l1.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the L1 data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_dcache_l1 -f files.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dcache_l1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

// File: source/d0_cache_ctrl.sv
// Stage-0 cache controller
// Decodes the request kind into per-way chip selects, write enables
// and byte enables for the tag/valid/dirty and data banks
`timescale 1ns/1ns

module d0_cache_ctrl (
  input  logic                                              d0_enable_i,
  input  dcache_pkg::d0_req_type_e                          d0_req_type_i,
  input  dcache_pkg::store_width_e                          store_width_i,
  input  logic [dcache_pkg::DCACHE_L1_BYTE_OFF_LEN-1:0]     byte_addr_in_line_i,
  // Registered lookup results from stage 1
  input  logic [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0]    hit_vec_i,
  input  logic [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0]    replace_vec_i,
  input  logic [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0]    d1_one_hot_dirty_vec_i,
  input  logic                                              d1_stalled_i,
  output dcache_pkg::tmem_ctrl_t [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0] tvd_ctrl_vec_o,
  output dcache_pkg::dmem_ctrl_t [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0] data_ctrl_vec_o,
  output logic [1:0]                                        tvd_wr_sel_o,
  output logic                                              rd_issue_o
);

  import dcache_pkg::*;

  // Byte enables of a store inside the line
  logic [DCACHE_L1_LINE_SIZE-1:0]     store_be;
  // Ways written in this cycle
  logic [DCACHE_L1_ASSOCIATIVITY-1:0] way_we;

  // Width-aligned enable mask, low offset bits ignored above byte size
  always_comb begin
    unique case (store_width_i)
      B:  store_be = DCACHE_L1_LINE_SIZE'(8'h01) << byte_addr_in_line_i;
      HW: store_be = DCACHE_L1_LINE_SIZE'(8'h03) << {byte_addr_in_line_i[4:1], 1'b0};
      W:  store_be = DCACHE_L1_LINE_SIZE'(8'h0f) << {byte_addr_in_line_i[4:2], 2'b00};
      DW: store_be = DCACHE_L1_LINE_SIZE'(8'hff) << {byte_addr_in_line_i[4:3], 3'b000};
      default: store_be = '0;
    endcase
  end

  always_comb begin
    // Idle unless a request is enabled
    tvd_ctrl_vec_o  = '0;
    data_ctrl_vec_o = '0;
    tvd_wr_sel_o    = TVD_WR_CLEAR;
    rd_issue_o      = 1'b0;
    if (d0_enable_i) begin
      unique case (d0_req_type_i)
        // Lookup in all ways
        d0_ReadLsq, d0_ReadD1, d0_ReadL2: begin
          rd_issue_o = 1'b1;
          for (int k = 0; k < DCACHE_L1_ASSOCIATIVITY; k++) begin
            tvd_ctrl_vec_o[k].cs  = 1'b1;
            tvd_ctrl_vec_o[k].be  = '1;
            data_ctrl_vec_o[k].cs = 1'b1;
            data_ctrl_vec_o[k].be = '1;
          end
        end
        // Whole line into the victim way
        d0_WriteCleanLineD1, d0_WriteDirtyLineD1: begin
          tvd_wr_sel_o = (d0_req_type_i == d0_WriteDirtyLineD1) ? TVD_WR_DIRTY : TVD_WR_VALID;
          for (int k = 0; k < DCACHE_L1_ASSOCIATIVITY; k++) begin
            tvd_ctrl_vec_o[k].cs  = replace_vec_i[k];
            tvd_ctrl_vec_o[k].we  = replace_vec_i[k];
            tvd_ctrl_vec_o[k].be  = '1;
            data_ctrl_vec_o[k].cs = replace_vec_i[k];
            data_ctrl_vec_o[k].we = replace_vec_i[k];
            data_ctrl_vec_o[k].be = '1;
          end
        end
        // Store into the hit way, only the low entry bytes so the
        // upper tag byte is untouched
        d0_WriteStoreD1: begin
          tvd_wr_sel_o = TVD_WR_DIRTY;
          for (int k = 0; k < DCACHE_L1_ASSOCIATIVITY; k++) begin
            tvd_ctrl_vec_o[k].cs  = hit_vec_i[k];
            tvd_ctrl_vec_o[k].we  = hit_vec_i[k];
            tvd_ctrl_vec_o[k].be  = 3'b011;
            data_ctrl_vec_o[k].cs = hit_vec_i[k];
            data_ctrl_vec_o[k].we = hit_vec_i[k];
            data_ctrl_vec_o[k].be = store_be;
          end
        end
        // Drop the dirty bit of the dirty hit way
        d0_CleanDirty: begin
          tvd_wr_sel_o = TVD_WR_VALID;
          for (int k = 0; k < DCACHE_L1_ASSOCIATIVITY; k++) begin
            tvd_ctrl_vec_o[k].cs = d1_one_hot_dirty_vec_i[k];
            tvd_ctrl_vec_o[k].we = d1_one_hot_dirty_vec_i[k];
            tvd_ctrl_vec_o[k].be = 3'b011;
          end
        end
        // Held back while stage 1 is stalled, requester re-issues
        d0_ReadUpdate: begin
          if (!d1_stalled_i) begin
            rd_issue_o = 1'b1;
            for (int k = 0; k < DCACHE_L1_ASSOCIATIVITY; k++) begin
              tvd_ctrl_vec_o[k].cs  = 1'b1;
              tvd_ctrl_vec_o[k].be  = '1;
              data_ctrl_vec_o[k].cs = 1'b1;
              data_ctrl_vec_o[k].be = '1;
            end
          end
        end
        // Invalidate the whole set
        d0_ResetLines: begin
          for (int k = 0; k < DCACHE_L1_ASSOCIATIVITY; k++) begin
            tvd_ctrl_vec_o[k].cs = 1'b1;
            tvd_ctrl_vec_o[k].we = 1'b1;
            tvd_ctrl_vec_o[k].be = '1;
          end
        end
        default: begin
          tvd_ctrl_vec_o  = '0;
          data_ctrl_vec_o = '0;
        end
      endcase
    end
  end

  always_comb begin
    for (int k = 0; k < DCACHE_L1_ASSOCIATIVITY; k++) begin
      way_we[k] = tvd_ctrl_vec_o[k].we | data_ctrl_vec_o[k].we;
    end
  end

  // Stage-1 vectors must never point at two ways for a line write
  always_comb begin
    if (d0_enable_i && (d0_req_type_i inside {d0_WriteCleanLineD1, d0_WriteDirtyLineD1,
                                              d0_WriteStoreD1})) begin
      assert final ($onehot0(way_we))
        else $error("ERR %0t: line write selects more than one way", $time);
    end
  end

endmodule

// File: source/d1_way_select.sv
// Stage-1 way selector
// Picks the hit line, registers hit and dirty vectors for stage 0
// and keeps a round-robin victim pointer per set
`timescale 1ns/1ns

module d1_way_select (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,
  input  logic                                                   rd_issue_i,
  input  logic [dcache_pkg::DCACHE_L1_IDX_LEN-1:0]               index_i,
  input  logic [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0]         hit_i,
  input  dcache_pkg::tvd_entry_t [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0] entry_vec_i,
  input  dcache_pkg::line_t [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0]      line_vec_i,
  output logic [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0]         hit_vec_o,
  output logic [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0]         replace_vec_o,
  output logic [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0]         one_hot_dirty_vec_o,
  output logic                                                   d1_valid_o,
  output logic                                                   d1_hit_o,
  output dcache_pkg::line_t                                      d1_line_o,
  output logic                                                   d1_dirty_o
);

  import dcache_pkg::*;

  logic                               valid_q;
  logic [DCACHE_L1_IDX_LEN-1:0]       idx_q;
  logic [DCACHE_L1_WAY_IDX_LEN-1:0]   rr_ptr_q [DCACHE_L1_N_SETS];
  logic [DCACHE_L1_ASSOCIATIVITY-1:0] hit_now;
  logic [DCACHE_L1_ASSOCIATIVITY-1:0] dirty_now;
  logic [DCACHE_L1_ASSOCIATIVITY-1:0] repl_now;
  logic                               inv_found;

  // Lookup issued in the previous cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rd_issue_i;
    end
  end

  always_ff @(posedge clk_i) begin
    idx_q <= index_i;
  end

  assign hit_now   = valid_q ? hit_i : '0;
  assign d1_valid_o = valid_q;
  assign d1_hit_o  = |hit_now;
  assign d1_dirty_o = |dirty_now;

  // One-hot line mux and dirty-hit vector
  always_comb begin
    d1_line_o = '0;
    for (int k = 0; k < DCACHE_L1_ASSOCIATIVITY; k++) begin
      dirty_now[k] = hit_now[k] & entry_vec_i[k].dirty;
      if (hit_now[k]) begin
        d1_line_o = d1_line_o | line_vec_i[k];
      end
    end
  end

  // Victim is the lowest invalid way, else the set pointer
  always_comb begin
    repl_now  = '0;
    inv_found = 1'b0;
    for (int k = 0; k < DCACHE_L1_ASSOCIATIVITY; k++) begin
      if (!entry_vec_i[k].valid && !inv_found) begin
        repl_now[k] = 1'b1;
        inv_found   = 1'b1;
      end
    end
    if (!inv_found) begin
      repl_now[rr_ptr_q[idx_q]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hit_vec_o           <= '0;
      one_hot_dirty_vec_o <= '0;
      replace_vec_o       <= '0;
      for (int s = 0; s < DCACHE_L1_N_SETS; s++) begin
        rr_ptr_q[s] <= '0;
      end
    end else if (valid_q) begin
      hit_vec_o           <= hit_now;
      one_hot_dirty_vec_o <= dirty_now;
      replace_vec_o       <= repl_now;
      // Full set and a miss, move on to the next victim
      if (!d1_hit_o && !inv_found) begin
        rr_ptr_q[idx_q] <= rr_ptr_q[idx_q] + 1'b1;
      end
    end
  end

  // A tag lives in one way of a set at most
  assert property (@(posedge clk_i) disable iff (!arst_n_i) valid_q |-> $onehot0(hit_i))
    else $error("ERR %0t: tag hits in more than one way", $time);

endmodule

// File: source/dcache_bank.sv
// Single-port synchronous memory bank
// Byte-enabled writes, registered reads, word type set by parameter
`timescale 1ns/1ns

module dcache_bank #(
  parameter type word_t = logic [7:0],
  parameter int  DEPTH  = 16
) (
  input  logic                           clk_i,
  input  logic                           cs_i,
  input  logic                           we_i,
  input  logic [$bits(word_t)/8-1:0]     be_i,
  input  logic [$clog2(DEPTH)-1:0]       addr_i,
  input  word_t                          wdata_i,
  output word_t                          rdata_o
);

  // Bytes per word
  localparam int N_BYTES = $bits(word_t) / 8;

  logic [N_BYTES-1:0][7:0] mem_q [DEPTH];
  logic [N_BYTES-1:0][7:0] wbytes;

  assign wbytes = wdata_i;

  // Write only the enabled bytes
  always_ff @(posedge clk_i) begin
    if (cs_i && we_i) begin
      for (int b = 0; b < N_BYTES; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b] <= wbytes[b];
        end
      end
    end
  end

  // Read data held until the next read
  always_ff @(posedge clk_i) begin
    if (cs_i && !we_i) begin
      rdata_o <= word_t'(mem_q[addr_i]);
    end
  end

  // Controller never writes an unselected bank
  assert property (@(posedge clk_i) we_i |-> cs_i)
    else $error("ERR %0t: bank write without chip select", $time);

endmodule

// File: source/dcache_l1_top.sv
// L1 data cache array top level
// Stage-0 controller, the ways and the stage-1 way selector
`timescale 1ns/1ns

module dcache_l1_top (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic                                          d0_enable_i,
  input  dcache_pkg::d0_req_type_e                      d0_req_type_i,
  input  dcache_pkg::store_width_e                      d0_store_width_i,
  input  logic [dcache_pkg::DCACHE_L1_IDX_LEN-1:0]      d0_index_i,
  input  logic [dcache_pkg::DCACHE_L1_TAG_LEN-1:0]      d0_tag_i,
  input  logic [dcache_pkg::DCACHE_L1_BYTE_OFF_LEN-1:0] d0_byte_off_i,
  input  logic [8*dcache_pkg::DCACHE_L1_WORD_SIZE-1:0]  d0_store_data_i,
  input  dcache_pkg::line_t                             d0_fill_line_i,
  input  logic                                          d1_stalled_i,
  output logic                                          d1_valid_o,
  output logic                                          d1_hit_o,
  output logic [dcache_pkg::DCACHE_L1_ASSOCIATIVITY-1:0] d1_hit_vec_o,
  output dcache_pkg::line_t                             d1_line_o,
  output logic                                          d1_dirty_o
);

  import dcache_pkg::*;

  tmem_ctrl_t [DCACHE_L1_ASSOCIATIVITY-1:0] tvd_ctrl_vec;
  dmem_ctrl_t [DCACHE_L1_ASSOCIATIVITY-1:0] data_ctrl_vec;
  tvd_entry_t [DCACHE_L1_ASSOCIATIVITY-1:0] entry_vec;
  line_t      [DCACHE_L1_ASSOCIATIVITY-1:0] line_vec;
  logic       [DCACHE_L1_ASSOCIATIVITY-1:0] way_hit;
  // Registered stage-1 vectors fed back to stage 0
  logic       [DCACHE_L1_ASSOCIATIVITY-1:0] hit_vec;
  logic       [DCACHE_L1_ASSOCIATIVITY-1:0] replace_vec;
  logic       [DCACHE_L1_ASSOCIATIVITY-1:0] dirty_vec;
  logic       [1:0]                         tvd_wr_sel;
  logic                                     rd_issue;

  d0_cache_ctrl d0_cache_ctrl_inst (
    .d0_enable_i            (d0_enable_i),
    .d0_req_type_i          (d0_req_type_i),
    .store_width_i          (d0_store_width_i),
    .byte_addr_in_line_i    (d0_byte_off_i),
    .hit_vec_i              (hit_vec),
    .replace_vec_i          (replace_vec),
    .d1_one_hot_dirty_vec_i (dirty_vec),
    .d1_stalled_i           (d1_stalled_i),
    .tvd_ctrl_vec_o         (tvd_ctrl_vec),
    .data_ctrl_vec_o        (data_ctrl_vec),
    .tvd_wr_sel_o           (tvd_wr_sel),
    .rd_issue_o             (rd_issue)
  );

  for (genvar w = 0; w < DCACHE_L1_ASSOCIATIVITY; w++) begin : gen_way
    dcache_way dcache_way_inst (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .tvd_ctrl_i   (tvd_ctrl_vec[w]),
      .data_ctrl_i  (data_ctrl_vec[w]),
      .tvd_wr_sel_i (tvd_wr_sel),
      .index_i      (d0_index_i),
      .tag_i        (d0_tag_i),
      .store_data_i (d0_store_data_i),
      .fill_line_i  (d0_fill_line_i),
      .entry_o      (entry_vec[w]),
      .line_o       (line_vec[w]),
      .hit_o        (way_hit[w])
    );
  end

  d1_way_select d1_way_select_inst (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .rd_issue_i          (rd_issue),
    .index_i             (d0_index_i),
    .hit_i               (way_hit),
    .entry_vec_i         (entry_vec),
    .line_vec_i          (line_vec),
    .hit_vec_o           (hit_vec),
    .replace_vec_o       (replace_vec),
    .one_hot_dirty_vec_o (dirty_vec),
    .d1_valid_o          (d1_valid_o),
    .d1_hit_o            (d1_hit_o),
    .d1_line_o           (d1_line_o),
    .d1_dirty_o          (d1_dirty_o)
  );

  // Raw per-way hits of the lookup in stage 1
  assign d1_hit_vec_o = way_hit;

endmodule

// File: source/dcache_pkg.sv
// L1 data cache shared definitions
// Geometry of the sets and ways, request and store encodings,
// tag/valid/dirty entry layout and the per-bank memory controls
package dcache_pkg;

  // Cache geometry
  localparam int DCACHE_L1_ASSOCIATIVITY = 4;
  localparam int DCACHE_L1_WAY_IDX_LEN   = 2;
  localparam int DCACHE_L1_N_SETS        = 16;
  localparam int DCACHE_L1_IDX_LEN       = 4;
  // Line and doubleword size in bytes
  localparam int DCACHE_L1_LINE_SIZE     = 32;
  localparam int DCACHE_L1_WORD_SIZE     = 8;
  localparam int DCACHE_L1_BYTE_OFF_LEN  = 5;
  // Tag/valid/dirty entry
  localparam int DCACHE_L1_TAG_LEN       = 22;
  localparam int DCACHE_L1_TVD_LEN       = 24;
  localparam int DCACHE_L1_TVD_BE_LEN    = 3;

  // Tvd write value codes, bit 1 is valid and bit 0 is dirty
  // All clear also wipes the tag
  localparam logic [1:0] TVD_WR_CLEAR = 2'b00;
  localparam logic [1:0] TVD_WR_VALID = 2'b10;
  localparam logic [1:0] TVD_WR_DIRTY = 2'b11;

  // Stage-0 request kinds
  typedef enum logic [3:0] {
    d0_ReadLsq,
    d0_ReadD1,
    d0_ReadL2,
    d0_WriteCleanLineD1,
    d0_WriteDirtyLineD1,
    d0_WriteStoreD1,
    d0_CleanDirty,
    d0_ReadUpdate,
    d0_ResetLines
  } d0_req_type_e;

  // Store size: byte, halfword, word, doubleword
  typedef enum logic [1:0] {B, HW, W, DW} store_width_e;

  // Dirty in bit 0, valid in bit 1, tag on top
  typedef struct packed {
    logic [DCACHE_L1_TAG_LEN-1:0] tag;
    logic                         valid;
    logic                         dirty;
  } tvd_entry_t;

  typedef logic [DCACHE_L1_LINE_SIZE-1:0][7:0] line_t;

  typedef struct packed {
    logic                            cs;
    logic                            we;
    logic [DCACHE_L1_TVD_BE_LEN-1:0] be;
  } tmem_ctrl_t;

  typedef struct packed {
    logic                           cs;
    logic                           we;
    logic [DCACHE_L1_LINE_SIZE-1:0] be;
  } dmem_ctrl_t;

endpackage

// File: source/dcache_way.sv
// One cache way
// Tag/valid/dirty bank and data bank, write value merge and tag compare
`timescale 1ns/1ns

module dcache_way (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  dcache_pkg::tmem_ctrl_t                        tvd_ctrl_i,
  input  dcache_pkg::dmem_ctrl_t                        data_ctrl_i,
  input  logic [1:0]                                    tvd_wr_sel_i,
  input  logic [dcache_pkg::DCACHE_L1_IDX_LEN-1:0]      index_i,
  input  logic [dcache_pkg::DCACHE_L1_TAG_LEN-1:0]      tag_i,
  input  logic [8*dcache_pkg::DCACHE_L1_WORD_SIZE-1:0]  store_data_i,
  input  dcache_pkg::line_t                             fill_line_i,
  output dcache_pkg::tvd_entry_t                        entry_o,
  output dcache_pkg::line_t                             line_o,
  output logic                                          hit_o
);

  import dcache_pkg::*;

  tvd_entry_t                   tvd_wdata;
  line_t                        line_wdata;
  logic                         tvd_rd;
  logic                         rd_q;
  logic [DCACHE_L1_TAG_LEN-1:0] cmp_tag_q;

  // Code zero clears everything, otherwise bits give valid and dirty
  assign tvd_wdata = (tvd_wr_sel_i == TVD_WR_CLEAR) ? '0 :
                     {tag_i, tvd_wr_sel_i[1], tvd_wr_sel_i[0]};

  // Full enable only on a fill, a store replicates its doubleword
  assign line_wdata = (&data_ctrl_i.be) ? fill_line_i :
                      line_t'({(DCACHE_L1_LINE_SIZE / DCACHE_L1_WORD_SIZE){store_data_i}});

  assign tvd_rd = tvd_ctrl_i.cs & ~tvd_ctrl_i.we;

  dcache_bank #(.word_t(tvd_entry_t), .DEPTH(DCACHE_L1_N_SETS)) tvd_bank_inst (
    .clk_i   (clk_i),
    .cs_i    (tvd_ctrl_i.cs),
    .we_i    (tvd_ctrl_i.we),
    .be_i    (tvd_ctrl_i.be),
    .addr_i  (index_i),
    .wdata_i (tvd_wdata),
    .rdata_o (entry_o)
  );

  dcache_bank #(.word_t(line_t), .DEPTH(DCACHE_L1_N_SETS)) data_bank_inst (
    .clk_i   (clk_i),
    .cs_i    (data_ctrl_i.cs),
    .we_i    (data_ctrl_i.we),
    .be_i    (data_ctrl_i.be),
    .addr_i  (index_i),
    .wdata_i (line_wdata),
    .rdata_o (line_o)
  );

  // Tag of the lookup in flight
  always_ff @(posedge clk_i) begin
    if (tvd_rd) begin
      cmp_tag_q <= tag_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= tvd_rd;
    end
  end

  assign hit_o = rd_q & entry_o.valid & (entry_o.tag == cmp_tag_q);

endmodule

// File: testbench/tb_dcache_l1.sv
// Testbench for the L1 data cache array
// LFSR stimulus against a per-set reference model
// Concurrent assertions check every stage-1 lookup
`timescale 1ns/1ns

module tb_dcache_l1;

  import dcache_pkg::*;

  localparam int NW = DCACHE_L1_ASSOCIATIVITY;
  localparam int NS = DCACHE_L1_N_SETS;
  localparam int RST_CYCLES = 10;
  // Requests of the six tests, each one takes two cycles
  localparam int OPS = 32 + 24 + 24 + 12 + 4 + 24;
  localparam int TEST_CYCLES = RST_CYCLES + 2 * OPS;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
  localparam int EXP_LOOKUPS = 16 + 16 + 16 + 8 + 2 + 16;

  typedef logic [DCACHE_L1_TAG_LEN-1:0] tag_t;

  logic                              clk_i;
  logic                              arst_n_i;
  logic                              d0_enable_i;
  d0_req_type_e                      d0_req_type_i;
  store_width_e                      d0_store_width_i;
  logic [DCACHE_L1_IDX_LEN-1:0]      d0_index_i;
  tag_t                              d0_tag_i;
  logic [DCACHE_L1_BYTE_OFF_LEN-1:0] d0_byte_off_i;
  logic [63:0]                       d0_store_data_i;
  line_t                             d0_fill_line_i;
  logic                              d1_stalled_i;
  logic                              d1_valid_o;
  logic                              d1_hit_o;
  logic [NW-1:0]                     d1_hit_vec_o;
  line_t                             d1_line_o;
  logic                              d1_dirty_o;

  // Reference model of every set
  tag_t  m_tag   [NS][NW];
  logic  m_valid [NS][NW];
  logic  m_dirty [NS][NW];
  line_t m_line  [NS][NW];
  logic [1:0] m_rr [NS];
  // Ways that the registered stage-1 vectors point at, -1 for none
  int m_hit_way   = -1;
  int m_repl_way  = -1;
  int m_dirty_way = -1;

  // Expected result of the lookup in flight
  logic          exp_issue = 1'b0;
  logic          issue_q;
  logic          exp_hit = 1'b0;
  logic          exp_dirty = 1'b0;
  logic [NW-1:0] exp_hit_vec = '0;
  line_t         exp_line = '0;

  int err_cnt   = 0;
  int bad_tests = 0;
  int look_cnt  = 0;
  int cyc_cnt   = 0;
  logic [15:0] lfsr_q = 16'd18438;

  dcache_l1_top dcache_l1_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Taps 16, 14, 13, 11, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  // Tag not held by any valid way of the set
  function automatic tag_t fresh_tag(input int s);
    tag_t t;
    logic used;
    do begin
      t = tag_t'(rand_bits(DCACHE_L1_TAG_LEN));
      used = 1'b0;
      for (int w = 0; w < NW; w++) begin
        if (m_valid[s][w] && m_tag[s][w] == t) used = 1'b1;
      end
    end while (used);
    return t;
  endfunction

  // One request cycle, then one idle cycle
  task automatic issue(input d0_req_type_e rq, input int s, input tag_t t);
    d0_enable_i   = 1'b1;
    d0_req_type_i = rq;
    d0_index_i    = DCACHE_L1_IDX_LEN'(s);
    d0_tag_i      = t;
    @(posedge clk_i);
    #5;
    d0_enable_i = 1'b0;
    exp_issue   = 1'b0;
    @(posedge clk_i);
    #5;
  endtask

  // Hit line, dirty hit, first invalid way or round-robin victim
  task automatic read_line(input d0_req_type_e rq, input int s, input tag_t t);
    int victim;
    exp_hit     = 1'b0;
    exp_dirty   = 1'b0;
    exp_hit_vec = '0;
    exp_line    = '0;
    m_hit_way   = -1;
    m_dirty_way = -1;
    victim      = -1;
    for (int w = 0; w < NW; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == t) begin
        exp_hit        = 1'b1;
        exp_hit_vec[w] = 1'b1;
        exp_line       = m_line[s][w];
        exp_dirty      = m_dirty[s][w];
        m_hit_way      = w;
        if (m_dirty[s][w]) m_dirty_way = w;
      end
      if (!m_valid[s][w] && victim < 0) victim = w;
    end
    if (victim < 0) begin
      victim = int'(m_rr[s]);
      // Full set and a miss
      if (!exp_hit) m_rr[s] = m_rr[s] + 2'd1;
    end
    m_repl_way = victim;
    exp_issue  = 1'b1;
    issue(rq, s, t);
  endtask

  task automatic fill(input int s, input tag_t t, input logic dirty);
    line_t ln;
    for (int q = 0; q < 4; q++) ln[q*8 +: 8] = rand_bits(64);
    if (m_repl_way >= 0) begin
      m_tag[s][m_repl_way]   = t;
      m_valid[s][m_repl_way] = 1'b1;
      m_dirty[s][m_repl_way] = dirty;
      m_line[s][m_repl_way]  = ln;
    end
    d0_fill_line_i = ln;
    if (dirty) issue(d0_WriteDirtyLineD1, s, t);
    else issue(d0_WriteCleanLineD1, s, t);
  endtask

  // Aligned bytes of the hit line take the replicated doubleword
  task automatic store(input int s, input tag_t t, input store_width_e wd,
                       input logic [4:0] off, input logic [63:0] data);
    int n;
    int base;
    n    = 1 << int'(wd);
    base = int'(off) & ~(n - 1);
    if (m_hit_way >= 0) begin
      for (int b = base; b < base + n; b++) begin
        m_line[s][m_hit_way][b] = data[8*(b%8) +: 8];
      end
      m_dirty[s][m_hit_way] = 1'b1;
    end
    d0_store_width_i = wd;
    d0_byte_off_i    = off;
    d0_store_data_i  = data;
    issue(d0_WriteStoreD1, s, t);
  endtask

  task automatic clean(input int s, input tag_t t);
    if (m_dirty_way >= 0) m_dirty[s][m_dirty_way] = 1'b0;
    issue(d0_CleanDirty, s, t);
  endtask

  task automatic reset_set(input int s);
    for (int w = 0; w < NW; w++) begin
      m_tag[s][w]   = '0;
      m_valid[s][w] = 1'b0;
      m_dirty[s][w] = 1'b0;
    end
    issue(d0_ResetLines, s, '0);
  endtask

  task automatic report_test(input string name, input int err_start);
    if (err_cnt == err_start) begin
      $display("%s: ok", name);
    end else begin
      bad_tests++;
      $display("%s: %0d errors", name, err_cnt - err_start);
    end
  endtask

  // Lookup valid follows the issued reads by one cycle
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) issue_q <= 1'b0;
    else issue_q <= exp_issue;
  end

  always @(negedge clk_i) begin
    if (arst_n_i && d1_valid_o) look_cnt++;
  end

  always @(posedge clk_i) begin
    cyc_cnt++;
    if (cyc_cnt > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cyc_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i) d1_valid_o == issue_q)
    else begin
      err_cnt++;
      $display("ERR %0t: lookup valid %0b, expected %0b", $time,
               $sampled(d1_valid_o), $sampled(issue_q));
    end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   d1_valid_o |-> (d1_hit_o == exp_hit && d1_hit_vec_o == exp_hit_vec))
    else begin
      err_cnt++;
      $display("ERR %0t: hit vector %b, expected %b", $time,
               $sampled(d1_hit_vec_o), $sampled(exp_hit_vec));
    end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   (d1_valid_o && exp_hit) |-> d1_line_o == exp_line)
    else begin
      err_cnt++;
      $display("ERR %0t: line %h, expected %h", $time, $sampled(d1_line_o), $sampled(exp_line));
    end

  assert property (@(posedge clk_i) disable iff (!arst_n_i) d1_valid_o |-> d1_dirty_o == exp_dirty)
    else begin
      err_cnt++;
      $display("ERR %0t: dirty %0b, expected %0b", $time,
               $sampled(d1_dirty_o), $sampled(exp_dirty));
    end

  initial begin
    tag_t hs_tag [8];
    tag_t old_tag [NW];
    int   e0;
    d0_enable_i      = 1'b0;
    d0_req_type_i    = d0_ReadLsq;
    d0_store_width_i = B;
    d0_index_i       = '0;
    d0_tag_i         = '0;
    d0_byte_off_i    = '0;
    d0_store_data_i  = '0;
    d0_fill_line_i   = '0;
    d1_stalled_i     = 1'b0;
    arst_n_i         = 1'b0;
    for (int s = 0; s < NS; s++) m_rr[s] = 2'd0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #5;
    arst_n_i = 1'b1;

    // Every set invalidated, then all lookups miss
    e0 = err_cnt;
    for (int s = 0; s < NS; s++) reset_set(s);
    for (int s = 0; s < NS; s++) begin
      read_line(d0_req_type_e'(s % 3), s, tag_t'(rand_bits(DCACHE_L1_TAG_LEN)));
    end
    report_test("reset and miss", e0);

    // Clean and dirty fills into the predicted victim
    e0 = err_cnt;
    for (int i = 0; i < 8; i++) begin
      hs_tag[i] = fresh_tag(i);
      read_line(d0_ReadD1, i, hs_tag[i]);
      fill(i, hs_tag[i], i[0]);
      read_line(d0_ReadL2, i, hs_tag[i]);
    end
    report_test("line fill", e0);

    // Each width twice at LFSR offsets
    e0 = err_cnt;
    for (int i = 0; i < 8; i++) begin
      read_line(d0_ReadLsq, i, hs_tag[i]);
      store(i, hs_tag[i], store_width_e'(i % 4), 5'(rand_bits(5)), rand_bits(64));
      read_line(d0_ReadD1, i, hs_tag[i]);
    end
    report_test("store widths", e0);

    e0 = err_cnt;
    for (int i = 0; i < 4; i++) begin
      read_line(d0_ReadLsq, i, hs_tag[i]);
      clean(i, hs_tag[i]);
      read_line(d0_ReadL2, i, hs_tag[i]);
    end
    report_test("dirty clean", e0);

    // Stalled read-update is dropped, re-issue hits
    e0 = err_cnt;
    for (int i = 4; i < 6; i++) begin
      d1_stalled_i = 1'b1;
      issue(d0_ReadUpdate, i, hs_tag[i]);
      d1_stalled_i = 1'b0;
      read_line(d0_ReadUpdate, i, hs_tag[i]);
    end
    report_test("stalled read-update", e0);

    // Set 12 filled, then four evictions in pointer order
    e0 = err_cnt;
    for (int w = 0; w < NW; w++) begin
      old_tag[w] = fresh_tag(12);
      read_line(d0_ReadLsq, 12, old_tag[w]);
      fill(12, old_tag[w], 1'b0);
    end
    for (int w = 0; w < NW; w++) begin
      hs_tag[0] = fresh_tag(12);
      read_line(d0_ReadD1, 12, hs_tag[0]);
      fill(12, hs_tag[0], 1'b1);
      // New line must sit in the way the pointer named
      read_line(d0_ReadLsq, 12, hs_tag[0]);
    end
    for (int w = 0; w < NW; w++) read_line(d0_ReadL2, 12, old_tag[w]);
    report_test("round-robin eviction", e0);

    assert (look_cnt == EXP_LOOKUPS)
      else begin
        err_cnt++;
        $display("ERR %0t: lookup count %0d, expected %0d", $time, look_cnt, EXP_LOOKUPS);
      end
    $display("tests 6, failing %0d, lookups %0d, errors %0d", bad_tests, look_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
